/* verilog/rv_branch_cfg.svh */
`ifndef RV_BRANCH_CFG_SVH
`define RV_BRANCH_CFG_SVH

// Width of data words, pc and branch target
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

`endif

/* verilog/rv_isa_pkg.sv */
`include "rv_branch_cfg.svh"

package rv_isa_pkg;

  ////////////////////////////////////////
  // Basic field types
  ////////////////////////////////////////

  // Register index, 5 bits for 32 registers
  typedef logic [4:0] reg_idx_t;

  // Data word as seen by the register file and bypass paths
  typedef logic [`RV_XLEN-1:0] word_t;

  // Major opcode field
  typedef logic [6:0] opcode_t;

  // Conditional branch major opcode
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  ////////////////////////////////////////
  // B-type encoding
  ////////////////////////////////////////

  // Branch condition in funct3
  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } br_funct3_e;

  // B-type instruction word, msb first
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
  } b_instr_t;

endpackage

/* verilog/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  import rv_isa_pkg::*;

  ////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////

  // IF/ID entry as latched from fetch
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    word_t       pc;
  } if_id_t;

  // Redirect sent back to fetch
  typedef struct packed {
    logic  valid;
    logic  taken;
    word_t target;
  } redirect_t;

  ////////////////////////////////////////
  // Operand source select
  ////////////////////////////////////////

  // EX/MEM bypass, MEM/WB bypass or register file
  typedef enum logic [1:0] {
    FWD_EX = 2'b00,
    FWD_WB = 2'b01,
    FWD_RF = 2'b11
  } fwd_sel_e;

endpackage

/* verilog/ex_mem_if.sv */
interface ex_mem_if;

  import rv_isa_pkg::*;

  // Results of the three execution units
  word_t    alures;
  word_t    divres;
  word_t    mulres;
  // Multicycle units flag a finished result
  logic     div_ready;
  logic     mul_ready;
  // Control of the instruction now in EX/MEM
  logic     regwrite;
  logic     memread;
  reg_idx_t rd;

  // Destination and control for the load-use check
  modport hazard (input rd, regwrite, memread);

  // Result values for the bypass mux
  modport forward (input alures, divres, mulres, div_ready, mul_ready);

  // Driver side at the top level
  modport source (output alures, divres, mulres, div_ready, mul_ready,
                  regwrite, memread, rd);

endinterface

/* verilog/pipe_reg.sv */
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     hold,
  input  payload_t d,
  output payload_t q
);

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  // Whole payload clears on reset
  // Valid bit low after reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (!hold) begin
      // Advance with the pipeline
      q <= d;
    end
    // Hold keeps the entry for a stalled stage
  end

endmodule

/* verilog/reg_file.sv */
`include "rv_branch_cfg.svh"

module reg_file (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                wr_en,
  input  rv_isa_pkg::reg_idx_t wr_idx,
  input  rv_isa_pkg::word_t    wr_data,
  input  rv_isa_pkg::reg_idx_t rd_idx_a,
  input  rv_isa_pkg::reg_idx_t rd_idx_b,
  output rv_isa_pkg::word_t    rd_data_a,
  output rv_isa_pkg::word_t    rd_data_b
);

  import rv_isa_pkg::*;

  // Architectural registers
  word_t regs [`RV_NREGS];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Written from MEM/WB at the clock edge
  // x0 never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  // Combinational reads, x0 reads as zero
  // Same-cycle write is not bypassed here
  assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

/* verilog/branch_hazard_detect.sv */
module branch_hazard_detect (
  ex_mem_if.hazard             ex,
  input  rv_isa_pkg::reg_idx_t wb_rd,
  input  logic                 id_valid,
  input  rv_isa_pkg::opcode_t  opcode,
  input  rv_isa_pkg::reg_idx_t rs1_idx,
  input  rv_isa_pkg::reg_idx_t rs2_idx,
  output logic                 is_branch,
  output logic                 hit_ex1,
  output logic                 hit_ex2,
  output logic                 hit_wb1,
  output logic                 hit_wb2,
  output logic                 stall
);

  import rv_isa_pkg::*;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Conditional branch in IF/ID
  // Shared with bypass and compare logic
  assign is_branch = (opcode == OPC_BRANCH);

  ////////////////////////////////////////
  // Index matches
  ////////////////////////////////////////

  // Source against EX/MEM destination
  // x0 is constant so it never matches
  assign hit_ex1 = (rs1_idx != '0) && (rs1_idx == ex.rd);
  assign hit_ex2 = (rs2_idx != '0) && (rs2_idx == ex.rd);

  // Source against MEM/WB destination
  assign hit_wb1 = (rs1_idx != '0) && (rs1_idx == wb_rd);
  assign hit_wb2 = (rs2_idx != '0) && (rs2_idx == wb_rd);

  ////////////////////////////////////////
  // Load-use stall
  ////////////////////////////////////////

  // Load data is not out of memory yet
  // Branch waits in IF/ID until the load leaves EX/MEM
  assign stall = id_valid && is_branch &&
                 ex.regwrite && ex.memread &&
                 (hit_ex1 || hit_ex2);

endmodule

/* verilog/branch_forward.sv */
module branch_forward (
  ex_mem_if.forward         ex,
  input  rv_isa_pkg::word_t wb_data,
  input  logic              ex_regwrite,
  input  logic              ex_memread,
  input  logic              wb_regwrite,
  input  logic              hit_ex1,
  input  logic              hit_ex2,
  input  logic              hit_wb1,
  input  logic              hit_wb2,
  input  rv_isa_pkg::word_t rs1,
  input  rv_isa_pkg::word_t rs2,
  output rv_isa_pkg::word_t rs1_mod,
  output rv_isa_pkg::word_t rs2_mod
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  word_t    exres;
  fwd_sel_e sel1;
  fwd_sel_e sel2;

  ////////////////////////////////////////
  // Source select
  ////////////////////////////////////////

  // EX/MEM wins over MEM/WB, the newer value
  // A load in EX/MEM has no data yet, stall covers it
  assign sel1 = (hit_ex1 && ex_regwrite && !ex_memread) ? FWD_EX :
                (hit_wb1 && wb_regwrite)                ? FWD_WB : FWD_RF;
  assign sel2 = (hit_ex2 && ex_regwrite && !ex_memread) ? FWD_EX :
                (hit_wb2 && wb_regwrite)                ? FWD_WB : FWD_RF;

  ////////////////////////////////////////
  // EX result
  ////////////////////////////////////////

  // Divider or multiplier only when it alone is ready
  // Both or neither falls back to the ALU
  always_comb begin
    case ({ex.div_ready, ex.mul_ready})
      2'b10:   exres = ex.divres;
      2'b01:   exres = ex.mulres;
      default: exres = ex.alures;
    endcase
  end

  ////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////

  // rs1 operand
  always_comb begin
    case (sel1)
      FWD_EX:  rs1_mod = exres;
      FWD_WB:  rs1_mod = wb_data;
      default: rs1_mod = rs1;
    endcase
  end

  // rs2 operand
  always_comb begin
    case (sel2)
      FWD_EX:  rs2_mod = exres;
      FWD_WB:  rs2_mod = wb_data;
      default: rs2_mod = rs2;
    endcase
  end

endmodule

/* verilog/branch_compare.sv */
`include "rv_branch_cfg.svh"

module branch_compare (
  input  rv_pipe_pkg::if_id_t    id,
  input  logic                   is_branch,
  input  logic                   stall,
  input  rv_isa_pkg::word_t      rs1_val,
  input  rv_isa_pkg::word_t      rs2_val,
  output rv_pipe_pkg::redirect_t redirect
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  b_instr_t   b;
  br_funct3_e funct3;
  word_t      imm;
  logic       eq;
  logic       lt_s;
  logic       lt_u;
  logic       taken;

  ////////////////////////////////////////
  // Fields
  ////////////////////////////////////////

  assign b      = b_instr_t'(id.instr);
  assign funct3 = br_funct3_e'(b.funct3);

  // B-immediate, even offset, sign extended
  assign imm = {{(`RV_XLEN-13){b.imm12}}, b.imm12, b.imm11,
                b.imm10_5, b.imm4_1, 1'b0};

  ////////////////////////////////////////
  // Condition
  ////////////////////////////////////////

  // Three basic relations cover all six branches
  assign eq   = (rs1_val == rs2_val);
  assign lt_s = ($signed(rs1_val) < $signed(rs2_val));
  assign lt_u = (rs1_val < rs2_val);

  always_comb begin
    case (funct3)
      F3_BEQ:  taken = eq;
      F3_BNE:  taken = !eq;
      F3_BLT:  taken = lt_s;
      F3_BGE:  taken = !lt_s;
      F3_BLTU: taken = lt_u;
      F3_BGEU: taken = !lt_u;
      // Reserved funct3 never redirects
      default: taken = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Redirect
  ////////////////////////////////////////

  // Only a branch that leaves IF/ID this cycle
  assign redirect.valid  = id.valid && is_branch && !stall;
  assign redirect.taken  = taken;
  // Target relative to the branch's own pc
  assign redirect.target = id.pc + imm;

endmodule

/* verilog/branch_unit_top.sv */
module branch_unit_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 in_valid,
  input  logic [31:0]          instr,
  input  rv_isa_pkg::word_t    pc,
  input  rv_isa_pkg::word_t    ex_alures,
  input  rv_isa_pkg::word_t    ex_divres,
  input  rv_isa_pkg::word_t    ex_mulres,
  input  logic                 ex_div_ready,
  input  logic                 ex_mul_ready,
  input  logic                 ex_regwrite,
  input  logic                 ex_memread,
  input  rv_isa_pkg::reg_idx_t ex_rd,
  input  logic                 wb_regwrite,
  input  rv_isa_pkg::reg_idx_t wb_rd,
  input  rv_isa_pkg::word_t    wb_data,
  output logic                 stall,
  output logic                 br_valid,
  output logic                 br_taken,
  output rv_isa_pkg::word_t    br_target
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  if_id_t    id_d;
  if_id_t    id_q;
  redirect_t redir_d;
  redirect_t redir_q;
  b_instr_t  id_b;
  word_t     rs1_rf;
  word_t     rs2_rf;
  word_t     rs1_val;
  word_t     rs2_val;
  logic      is_branch;
  logic      hit_ex1;
  logic      hit_ex2;
  logic      hit_wb1;
  logic      hit_wb2;

  ////////////////////////////////////////
  // EX/MEM bus
  ////////////////////////////////////////

  ex_mem_if ex_bus ();

  assign ex_bus.alures    = ex_alures;
  assign ex_bus.divres    = ex_divres;
  assign ex_bus.mulres    = ex_mulres;
  assign ex_bus.div_ready = ex_div_ready;
  assign ex_bus.mul_ready = ex_mul_ready;
  assign ex_bus.regwrite  = ex_regwrite;
  assign ex_bus.memread   = ex_memread;
  assign ex_bus.rd        = ex_rd;

  ////////////////////////////////////////
  // IF/ID
  ////////////////////////////////////////

  // Held while stalled, new input dropped meanwhile
  assign id_d = '{valid: in_valid, instr: instr, pc: pc};

  pipe_reg #(.payload_t(if_id_t)) u_if_id (
    .clk    (clk),
    .arst_n (arst_n),
    .hold   (stall),
    .d      (id_d),
    .q      (id_q)
  );

  assign id_b = b_instr_t'(id_q.instr);

  ////////////////////////////////////////
  // Operands
  ////////////////////////////////////////

  reg_file u_reg_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_en     (wb_regwrite),
    .wr_idx    (wb_rd),
    .wr_data   (wb_data),
    .rd_idx_a  (id_b.rs1),
    .rd_idx_b  (id_b.rs2),
    .rd_data_a (rs1_rf),
    .rd_data_b (rs2_rf)
  );

  branch_hazard_detect u_hazard (
    .ex        (ex_bus.hazard),
    .wb_rd     (wb_rd),
    .id_valid  (id_q.valid),
    .opcode    (id_b.opcode),
    .rs1_idx   (id_b.rs1),
    .rs2_idx   (id_b.rs2),
    .is_branch (is_branch),
    .hit_ex1   (hit_ex1),
    .hit_ex2   (hit_ex2),
    .hit_wb1   (hit_wb1),
    .hit_wb2   (hit_wb2),
    .stall     (stall)
  );

  branch_forward u_forward (
    .ex          (ex_bus.forward),
    .wb_data     (wb_data),
    .ex_regwrite (ex_regwrite),
    .ex_memread  (ex_memread),
    .wb_regwrite (wb_regwrite),
    .hit_ex1     (hit_ex1),
    .hit_ex2     (hit_ex2),
    .hit_wb1     (hit_wb1),
    .hit_wb2     (hit_wb2),
    .rs1         (rs1_rf),
    .rs2         (rs2_rf),
    .rs1_mod     (rs1_val),
    .rs2_mod     (rs2_val)
  );

  ////////////////////////////////////////
  // Resolve and register
  ////////////////////////////////////////

  branch_compare u_compare (
    .id        (id_q),
    .is_branch (is_branch),
    .stall     (stall),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .redirect  (redir_d)
  );

  // Loads every cycle, invalid entry while stalled
  pipe_reg #(.payload_t(redirect_t)) u_redirect (
    .clk    (clk),
    .arst_n (arst_n),
    .hold   (1'b0),
    .d      (redir_d),
    .q      (redir_q)
  );

  assign br_valid  = redir_q.valid;
  assign br_taken  = redir_q.taken;
  assign br_target = redir_q.target;

endmodule

/* test/branch_unit_tb.sv */
`include "rv_branch_cfg.svh"

module branch_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import rv_isa_pkg::*;

  localparam int TIMEOUT    = 20;
  localparam int LINE_BYTES = 256;

  // DUT ports
  logic        clk;
  logic        arst_n;
  logic        in_valid;
  logic [31:0] instr;
  word_t       pc;
  word_t       ex_alures;
  word_t       ex_divres;
  word_t       ex_mulres;
  logic        ex_div_ready;
  logic        ex_mul_ready;
  logic        ex_regwrite;
  logic        ex_memread;
  reg_idx_t    ex_rd;
  logic        wb_regwrite;
  reg_idx_t    wb_rd;
  word_t       wb_data;
  logic        stall;
  logic        br_valid;
  logic        br_taken;
  word_t       br_target;

  // Fields of the current trace line
  logic [7:0]      tr_kind;
  logic [8*24-1:0] tr_name;
  int              tr_f3;
  int              tr_rs1;
  int              tr_rs2;
  integer          tr_imm;
  word_t           tr_pc;
  int              tr_exrw;
  int              tr_exmr;
  int              tr_exrd;
  int              tr_dv;
  int              tr_mu;
  word_t           tr_alu;
  word_t           tr_div;
  word_t           tr_mul;
  int              tr_wbrw;
  int              tr_wbrd;
  word_t           tr_wbd;
  int              tr_taken;
  word_t           tr_target;

  // Reference register image with x0 held at zero
  word_t  ref_regs [`RV_NREGS];
  integer seed;
  int     test_errors;
  int     tests;
  int     fails;

  branch_unit_top uut (.*);

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Bypass priority EX/MEM, then MEM/WB, then register file
  function automatic word_t operand_value(input int idx);
    word_t ex_val;
    bit    ex_fwd;
    ex_val = (tr_dv && !tr_mu) ? tr_div : (tr_mu && !tr_dv) ? tr_mul : tr_alu;
    // Load-use lines resolve after the load flag drops
    ex_fwd = tr_exrw && !(tr_exmr && tr_kind != "L");
    if (idx != 0 && idx == tr_exrd && ex_fwd) begin
      return ex_val;
    end else if (idx != 0 && idx == tr_wbrd && tr_wbrw) begin
      return tr_wbd;
    end
    return ref_regs[idx];
  endfunction

  task automatic reference_result(output bit taken, output word_t target);
    word_t a;
    word_t b;
    a = operand_value(tr_rs1);
    b = operand_value(tr_rs2);
    case (tr_f3)
      0:       taken = (a == b);
      1:       taken = (a != b);
      4:       taken = ($signed(a) < $signed(b));
      5:       taken = ($signed(a) >= $signed(b));
      6:       taken = (a < b);
      default: taken = (a >= b);
    endcase
    target = tr_pc + word_t'(tr_imm);
  endtask

  // B-type layout with the immediate scattered
  function automatic logic [31:0] branch_word(input logic [6:0] opcode);
    logic [12:0] imm;
    imm = tr_imm[12:0];
    return {imm[12], imm[10:5], tr_rs2[4:0], tr_rs1[4:0], tr_f3[2:0],
            imm[4:1], imm[11], opcode};
  endfunction

  ////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////

  task automatic check_eq(input logic [8*16-1:0] what, input word_t exp, input word_t act);
    assert (exp === act) else begin
      $display("** Error %0s %0s: expected %h, actual %h", tr_name, what, exp, act);
      test_errors++;
    end
  endtask

  // Register write through the MEM/WB port that lands on the next edge
  task automatic write_reg(input int idx, input word_t val);
    @(posedge clk);
    wb_regwrite <= 1'b1;
    wb_rd       <= reg_idx_t'(idx);
    wb_data     <= val;
    if (idx != 0) begin
      ref_regs[idx] = val;
    end
  endtask

  task automatic release_inputs();
    @(posedge clk);
    in_valid     <= 1'b0;
    ex_regwrite  <= 1'b0;
    ex_memread   <= 1'b0;
    ex_div_ready <= 1'b0;
    ex_mul_ready <= 1'b0;
    wb_regwrite  <= 1'b0;
  endtask

  // Count negedges until br_valid or return zero on timeout
  task automatic wait_redirect(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!br_valid && cycles < TIMEOUT);
    if (!br_valid) begin
      cycles = 0;
    end
  endtask

  task automatic report_test();
    tests++;
    if (test_errors != 0) begin
      fails++;
      $display("FAIL %0s", tr_name);
    end else begin
      $display("PASS %0s", tr_name);
    end
  endtask

  task automatic run_test();
    bit    exp_taken;
    word_t exp_target;
    int    cycles;
    int    n;
    test_errors = 0;
    reference_result(exp_taken, exp_target);
    // Trace values against the reference
    if (tr_kind != "N") begin
      check_eq("trace taken", word_t'(exp_taken), word_t'(tr_taken));
      check_eq("trace target", exp_target, tr_target);
    end
    @(posedge clk);
    in_valid     <= 1'b1;
    instr        <= branch_word((tr_kind == "N") ? 7'b0110011 : OPC_BRANCH);
    pc           <= tr_pc;
    ex_regwrite  <= tr_exrw[0];
    ex_memread   <= tr_exmr[0];
    ex_rd        <= reg_idx_t'(tr_exrd);
    ex_div_ready <= tr_dv[0];
    ex_mul_ready <= tr_mu[0];
    ex_alures    <= tr_alu;
    ex_divres    <= tr_div;
    ex_mulres    <= tr_mul;
    // IF/ID takes the single strobe on this edge
    @(posedge clk);
    in_valid <= 1'b0;
    // MEM/WB result present while the branch sits in IF/ID
    // Register file only sees it at the following edge
    wb_regwrite  <= tr_wbrw[0];
    wb_rd        <= reg_idx_t'(tr_wbrd);
    wb_data      <= tr_wbd;
    if (tr_kind == "L") begin
      n = 0;
      do begin
        @(negedge clk);
        n++;
      end while (!stall && n < TIMEOUT);
      assert (stall) else begin
        $display("%0s: stall did not rise within %0d cycles", tr_name, TIMEOUT);
        test_errors++;
      end
      // Branch parked so nothing leaves
      repeat (3) begin
        @(negedge clk);
        assert (stall && !br_valid) else begin
          $display("%0s: branch left IF/ID while the load was in EX/MEM", tr_name);
          test_errors++;
        end
      end
      // Load data now available
      @(posedge clk);
      ex_memread <= 1'b0;
    end
    wait_redirect(cycles);
    if (tr_kind == "N") begin
      assert (cycles == 0 && !stall) else begin
        $display("%0s: non-branch instruction raised br_valid or stall", tr_name);
        test_errors++;
      end
    end else begin
      assert (cycles != 0) else begin
        $display("%0s: no br_valid within %0d cycles", tr_name, TIMEOUT);
        test_errors++;
      end
      if (cycles != 0) begin
        check_eq("latency", 32'd2, word_t'(cycles));
        check_eq("taken", word_t'(exp_taken), word_t'(br_taken));
        check_eq("target", exp_target, br_target);
        @(negedge clk);
        assert (!br_valid) else begin
          $display("%0s: br_valid stayed high for more than one cycle", tr_name);
          test_errors++;
        end
      end
    end
    release_inputs();
    if (tr_wbrw != 0 && tr_wbrd != 0) begin
      ref_regs[tr_wbrd] = tr_wbd;
    end
    report_test();
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    integer                  fd;
    integer                  cnt;
    logic [8*LINE_BYTES-1:0] line;
    logic [8*8-1:0]          tag;
    int                      idx;
    word_t                   val;
    seed   = 32'h39c2_768b;
    tests  = 0;
    fails  = 0;
    arst_n       <= 1'b0;
    in_valid     <= 1'b0;
    instr        <= '0;
    pc           <= '0;
    ex_alures    <= '0;
    ex_divres    <= '0;
    ex_mulres    <= '0;
    ex_div_ready <= 1'b0;
    ex_mul_ready <= 1'b0;
    ex_regwrite  <= 1'b0;
    ex_memread   <= 1'b0;
    ex_rd        <= '0;
    wb_regwrite  <= 1'b0;
    wb_rd        <= '0;
    wb_data      <= '0;
    for (int i = 0; i < `RV_NREGS; i++) begin
      ref_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    // Outputs quiet out of reset
    tr_name     = "reset";
    tr_wbrw     = 0;
    test_errors = 0;
    @(negedge clk);
    assert (!stall && !br_valid) else begin
      $display("reset: stall or br_valid high after reset");
      test_errors++;
    end
    report_test();

    // Background register contents that trace preloads override
    for (int i = 1; i < `RV_NREGS; i++) begin
      write_reg(i, $random(seed));
    end

    fd = $fopen("test/branch_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/branch_trace.txt");
      fails++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        tag  = '0;
        cnt  = $fgets(line, fd);
        cnt  = $sscanf(line, "%s", tag);
        if (cnt == 1 && tag == "P") begin
          cnt = $sscanf(line, "%s %d %h", tag, idx, val);
          write_reg(idx, val);
        end else if (cnt == 1 && (tag == "B" || tag == "L" || tag == "N")) begin
          cnt = $sscanf(line,
            "%s %s %d %d %d %d %h %d %d %d %d %d %h %h %h %d %d %h %d %h",
            tr_kind, tr_name, tr_f3, tr_rs1, tr_rs2, tr_imm, tr_pc,
            tr_exrw, tr_exmr, tr_exrd, tr_dv, tr_mu, tr_alu, tr_div, tr_mul,
            tr_wbrw, tr_wbrd, tr_wbd, tr_taken, tr_target);
          assert (cnt == 20) else begin
            $display("Malformed trace line for test %0s", tr_name);
            fails++;
          end
          if (cnt == 20) begin
            run_test();
          end
        end
      end
      $fclose(fd);
    end

    $display("Tests run %0d, passed %0d, failed %0d", tests, tests - fails, fails);
    if (fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* test/branch_trace.txt */
# P idx value_hex : register preload through the WB port
# kind name f3 rs1 rs2 imm_dec pc_hex ex_rw ex_mr ex_rd div_rdy mul_rdy alu div mul wb_rw wb_rd wb_data taken target
P 1 00000005
P 2 00000005
P 3 00000007
P 4 ffffffff
P 5 00000001
P 6 80000000
P 7 7fffffff
# Conditions straight from the register file
B beq_taken     0  1  2    16  100  0 0  0 0 0 0 0 0  0  0 0  1 110
B beq_not_taken 0  1  3    16  100  0 0  0 0 0 0 0 0  0  0 0  0 110
B bne_taken     1  1  3    -8  200  0 0  0 0 0 0 0 0  0  0 0  1 1f8
B blt_signed    4  4  5   -16  300  0 0  0 0 0 0 0 0  0  0 0  1 2f0
B bltu_unsigned 6  4  5   -16  300  0 0  0 0 0 0 0 0  0  0 0  0 2f0
B bge_signed    5  6  7  4094 1000  0 0  0 0 0 0 0 0  0  0 0  0 1ffe
B bgeu_unsigned 7  6  7 -4096 2000  0 0  0 0 0 0 0 0  0  0 0  1 1000
B bge_equal     5  1  2     8    0  0 0  0 0 0 0 0 0  0  0 0  1 8
# EX/MEM bypass by unit readiness
B ex_alu_rs1    0  1  2    12  400  1 0  1 0 0 9 5 5  0  0 0  0 40c
B ex_div_rs2    0  1  2    12  400  1 0  2 1 0 5 9 5  0  0 0  0 40c
B ex_mul_rs1    0  1  2    12  400  1 0  1 0 1 5 5 9  0  0 0  0 40c
B ex_mul_rs2    0  1  3    12  400  1 0  3 0 1 9 9 5  0  0 0  1 40c
B ex_both_alu   0  1  3    12  400  1 0  3 1 1 5 9 9  0  0 0  1 40c
# MEM/WB bypass, priority, x0
B wb_rs1        0  8  1    20  500  0 0  0 0 0 0 0 0  1  8 5  1 514
B wb_rs2        1  1  9    20  500  0 0  0 0 0 0 0 0  1  9 5  0 514
B ex_over_wb    0  1 10    24  600  1 0 10 0 0 5 0 0  1 10 6  1 618
B x0_no_fwd     0  0  5     4  680  1 0  0 0 0 1 0 0  1  0 1  0 684
# Load-use stall, then release
L load_use_rs1  1  1  2    32  700  1 1  1 0 0 9 0 0  0  0 0  1 720
L load_use_rs2  4  3  2   -32  700  1 1  2 0 0 8 0 0  0  0 0  1 6e0
# Non-branch passes without redirect
N alu_op        0  1  2     0  800  0 0  0 0 0 0 0 0  0  0 0  0 0

/* files.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/ex_mem_if.sv
verilog/pipe_reg.sv
verilog/reg_file.sv
verilog/branch_hazard_detect.sv
verilog/branch_forward.sv
verilog/branch_compare.sv
verilog/branch_unit_top.sv
test/branch_unit_tb.sv
